/* Bender.yml */
package:
  name: dwc_upsize

export_include_dirs:
  - common

sources:
  # Synthesizable upsizer
  - target: rtl
    files:
      - common/dwc_pkg.sv
      - dwc_upsize/dwc_lane_steer.sv
      - dwc_upsize/dwc_lane_slot.sv
      - dwc_upsize/dwc_wide_packer.sv
      - design/dwc_upsize_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_dwc_clk_gen.sv
      - verif/tb_dwc_upsize.sv

/* build.f */
+incdir+common
common/dwc_pkg.sv
dwc_upsize/dwc_lane_steer.sv
dwc_upsize/dwc_lane_slot.sv
dwc_upsize/dwc_wide_packer.sv
design/dwc_upsize_top.sv
verif/tb_dwc_clk_gen.sv
verif/tb_dwc_upsize.sv

/* common/dwc_config.svh */
// Upsizer width configuration
`ifndef DWC_CONFIG_SVH
`define DWC_CONFIG_SVH

// Narrow side data width in bits
`define DWC_NARROW_W 32

// Narrow lanes per wide word
`define DWC_RATIO 4

// Wide side data width, always a whole number of narrow lanes
`define DWC_WIDE_W (`DWC_NARROW_W * `DWC_RATIO)

// Bits needed to name one lane
`define DWC_LANE_IDX_W 2

// Byte strobe widths on both sides
`define DWC_NARROW_STRB_W (`DWC_NARROW_W / 8)
`define DWC_WIDE_STRB_W (`DWC_WIDE_W / 8)

`endif

/* common/dwc_pkg.sv */
// Upsizer shared types
`include "dwc_config.svh"

package dwc_pkg;

  // One narrow write data beat
  typedef struct packed {
    logic [`DWC_NARROW_W-1:0]      data;
    logic [`DWC_NARROW_STRB_W-1:0] strb;
    // First beat of a burst
    logic                          first;
    // Lane picked by the burst start address, first beat only
    logic [`DWC_LANE_IDX_W-1:0]    start_lane;
    logic                          last;
  } narrow_beat_t;

  // Per-cycle lane write command from the steer
  typedef struct packed {
    logic                          en;
    logic [`DWC_LANE_IDX_W-1:0]    lane;
    logic [`DWC_NARROW_W-1:0]      data;
    logic [`DWC_NARROW_STRB_W-1:0] strb;
    // Wide beat closes with this write
    logic                          flush;
    logic                          last;
  } lane_wr_t;

  // Wide word, flat at the port and per lane inside the packer
  typedef union packed {
    logic [`DWC_WIDE_W-1:0]                     flat;
    logic [`DWC_RATIO-1:0][`DWC_NARROW_W-1:0] lanes;
  } wide_word_u;

  // One wide write data beat
  typedef struct packed {
    wide_word_u                  word;
    logic [`DWC_WIDE_STRB_W-1:0] strb;
    logic                        last;
  } wide_beat_t;

endpackage

/* design/dwc_upsize_top.sv */
// Write data upsizer top
`include "dwc_config.svh"

module dwc_upsize_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Narrow write data stream
  input  dwc_pkg::narrow_beat_t in_beat,
  input  logic                  in_valid,
  output logic                  in_ready,
  // Wide write data stream
  output dwc_pkg::wide_beat_t   out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);

  dwc_pkg::lane_wr_t                             lane_wr;
  logic [`DWC_RATIO-1:0][`DWC_NARROW_W-1:0]      slot_data;
  logic [`DWC_RATIO-1:0][`DWC_NARROW_STRB_W-1:0] slot_strb;
  logic                                          stall;

  // Lane selection and flush decision
  dwc_lane_steer u_steer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .stall    (stall),
    .lane_wr  (lane_wr)
  );

  // One holding slot per narrow lane
  for (genvar i = 0; i < `DWC_RATIO; i++) begin : g_slot
    dwc_lane_slot #(
      .lane_id (i)
    ) u_slot (
      .clk       (clk),
      .rst_n     (rst_n),
      .lane_wr   (lane_wr),
      .slot_data (slot_data[i]),
      .slot_strb (slot_strb[i])
    );
  end

  // Wide output register and back-pressure
  dwc_wide_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .lane_wr   (lane_wr),
    .slot_data (slot_data),
    .slot_strb (slot_strb),
    .stall     (stall),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* dwc_upsize/dwc_lane_slot.sv */
// Single lane holding slot
`include "dwc_config.svh"

module dwc_lane_slot #(
  // Lane this slot serves
  parameter int unsigned lane_id = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  dwc_pkg::lane_wr_t             lane_wr,
  output logic [`DWC_NARROW_W-1:0]      slot_data,
  output logic [`DWC_NARROW_STRB_W-1:0] slot_strb
);

  logic hit;
  logic capture;
  logic clear;

  assign hit = lane_wr.lane == `DWC_LANE_IDX_W'(lane_id);

  // Flushing writes go straight to the packer, never into a slot
  assign capture = lane_wr.en & ~lane_wr.flush & hit;

  // Any flush empties every slot for the next wide word
  assign clear = lane_wr.en & lane_wr.flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_data <= '0;
      slot_strb <= '0;
    end else if (clear) begin
      // Zero data too so unwritten lanes leave clean
      slot_data <= '0;
      slot_strb <= '0;
    end else if (capture) begin
      slot_data <= lane_wr.data;
      slot_strb <= lane_wr.strb;
    end
  end

endmodule

/* dwc_upsize/dwc_lane_steer.sv */
// Narrow beat lane steering
`include "dwc_config.svh"

module dwc_lane_steer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dwc_pkg::narrow_beat_t in_beat,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic                 stall,
  output dwc_pkg::lane_wr_t    lane_wr
);

  // MSB set means no burst in flight, next beat must be a first beat
  localparam logic [`DWC_LANE_IDX_W:0] cnt_idle = {1'b1, {`DWC_LANE_IDX_W{1'b0}}};

  logic [`DWC_LANE_IDX_W:0]   cnt_q;
  logic [`DWC_LANE_IDX_W-1:0] lane;
  logic [`DWC_LANE_IDX_W-1:0] lane_inc;
  logic                       accept;

  // Only back-pressure source on the narrow side
  assign in_ready = ~stall;
  assign accept   = in_valid & in_ready;

  // First beat jumps to the start address lane
  assign lane     = in_beat.first ? in_beat.start_lane : cnt_q[`DWC_LANE_IDX_W-1:0];
  // Wraps to lane 0 of the next wide word
  assign lane_inc = lane + 1'b1;

  always_comb begin
    lane_wr.en    = accept;
    lane_wr.lane  = lane;
    lane_wr.data  = in_beat.data;
    lane_wr.strb  = in_beat.strb;
    // Close the wide beat at the top lane or at burst end
    lane_wr.flush = (lane == `DWC_LANE_IDX_W'(`DWC_RATIO - 1)) | in_beat.last;
    lane_wr.last  = in_beat.last;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= cnt_idle;
    end else if (accept) begin
      if (in_beat.last) begin
        cnt_q <= cnt_idle;
      end else begin
        cnt_q <= {1'b0, lane_inc};
      end
    end
  end

  // A follow-on beat needs a burst that was opened by a first beat
  property p_no_orphan_beat;
    @(posedge clk) disable iff (!rst_n)
      (in_valid && !in_beat.first) |-> !cnt_q[`DWC_LANE_IDX_W];
  endproperty

  a_no_orphan_beat: assert property (p_no_orphan_beat)
    else $error("narrow beat without an open burst");

endmodule

/* dwc_upsize/dwc_wide_packer.sv */
// Wide beat packer
`include "dwc_config.svh"

module dwc_wide_packer (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  dwc_pkg::lane_wr_t                              lane_wr,
  input  logic [`DWC_RATIO-1:0][`DWC_NARROW_W-1:0]      slot_data,
  input  logic [`DWC_RATIO-1:0][`DWC_NARROW_STRB_W-1:0] slot_strb,
  output logic                                           stall,
  output dwc_pkg::wide_beat_t                            out_beat,
  output logic                                           out_valid,
  input  logic                                           out_ready
);

  dwc_pkg::wide_word_u                           nxt_word;
  logic [`DWC_RATIO-1:0][`DWC_NARROW_STRB_W-1:0] nxt_strb;
  logic                                          load;

  // Held beat not yet taken blocks the narrow side
  assign stall = out_valid & ~out_ready;

  // Steer only issues writes while not stalled
  assign load = lane_wr.en & lane_wr.flush;

  // Flushing beat bypasses its slot and lands in its lane directly
  always_comb begin
    nxt_word = '0;
    nxt_strb = '0;
    for (int i = 0; i < `DWC_RATIO; i++) begin
      if (lane_wr.lane == `DWC_LANE_IDX_W'(i)) begin
        nxt_word.lanes[i] = lane_wr.data;
        nxt_strb[i]       = lane_wr.strb;
      end else begin
        nxt_word.lanes[i] = slot_data[i];
        nxt_strb[i]       = slot_strb[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Output payload
  always_ff @(posedge clk) begin
    if (load) begin
      out_beat.word <= nxt_word;
      out_beat.strb <= nxt_strb;
      out_beat.last <= lane_wr.last;
    end
  end

  // Offered beat must not change until the sink takes it
  property p_out_stable;
    @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_beat));
  endproperty

  a_out_stable: assert property (p_out_stable)
    else $error("wide beat changed under back-pressure");

endmodule

/* verif/dwc_upsize_stim.txt */
# N max_gap first start_lane last strb data / E last strb wide_data (lane 3 leftmost)
# R ready pattern in hex, one bit per cycle from the LSB, repeating
R ff5000ffff00ffff
# Aligned burst from lane 0
N 0 1 0 0 f 11111111
N 0 0 0 0 f 22222222
N 0 0 0 0 f 33333333
N 0 0 0 1 f 44444444
E 1 ffff 44444444333333332222222211111111
# Burst starting at lane 2
N 0 1 2 0 f a1a1a1a1
N 0 0 0 0 f a2a2a2a2
E 0 ff00 a2a2a2a2a1a1a1a10000000000000000
N 0 0 0 0 f a3a3a3a3
N 0 0 0 0 f a4a4a4a4
N 0 0 0 0 f a5a5a5a5
N 0 0 0 1 f a6a6a6a6
E 1 ffff a6a6a6a6a5a5a5a5a4a4a4a4a3a3a3a3
# Short bursts ending mid-word
N 0 1 0 0 f b1b1b1b1
N 0 0 0 1 f b2b2b2b2
E 1 00ff 0000000000000000b2b2b2b2b1b1b1b1
N 0 1 1 1 f c1c1c1c1
E 1 00f0 0000000000000000c1c1c1c100000000
# Partial strobes
N 0 1 1 0 3 d1d1d1d1
N 0 0 0 0 c d2d2d2d2
N 0 0 0 1 6 d3d3d3d3
E 1 6c30 d3d3d3d3d2d2d2d2d1d1d1d100000000
N 0 1 0 0 1 e1e1e1e1
N 0 0 0 0 2 e2e2e2e2
N 0 0 0 0 4 e3e3e3e3
N 0 0 0 0 8 e4e4e4e4
E 0 8421 e4e4e4e4e3e3e3e3e2e2e2e2e1e1e1e1
N 0 0 0 1 9 e5e5e5e5
E 1 0009 000000000000000000000000e5e5e5e5
# Runs into the long ready-low window
N 0 1 0 0 f 5a000001
N 0 0 0 0 f 5a000002
N 0 0 0 0 f 5a000003
N 0 0 0 1 f 5a000004
E 1 ffff 5a0000045a0000035a0000025a000001
# Same bursts again with random valid gaps
N 3 1 2 0 f a1a1a1a1
N 3 0 0 0 f a2a2a2a2
E 0 ff00 a2a2a2a2a1a1a1a10000000000000000
N 3 0 0 0 f a3a3a3a3
N 3 0 0 0 f a4a4a4a4
N 3 0 0 0 f a5a5a5a5
N 3 0 0 1 f a6a6a6a6
E 1 ffff a6a6a6a6a5a5a5a5a4a4a4a4a3a3a3a3
N 3 1 0 0 1 e1e1e1e1
N 3 0 0 0 2 e2e2e2e2
N 3 0 0 0 4 e3e3e3e3
N 3 0 0 0 8 e4e4e4e4
E 0 8421 e4e4e4e4e3e3e3e3e2e2e2e2e1e1e1e1
N 3 0 0 1 9 e5e5e5e5
E 1 0009 000000000000000000000000e5e5e5e5

/* verif/tb_dwc_clk_gen.sv */
// Testbench clock and reset
module tb_dwc_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns clock period
  localparam int half_period = 5;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Reset held low for the first 2 clock cycles
  initial begin
    rst_n = 1'b0;
    #(4 * half_period) rst_n = 1'b1;
  end

endmodule

/* verif/tb_dwc_upsize.sv */
// Upsizer testbench
`include "dwc_config.svh"

module tb_dwc_upsize;

  timeunit 1ns;
  timeprecision 1ps;

  logic                  clk;
  logic                  rst_n;
  dwc_pkg::narrow_beat_t in_beat;
  logic                  in_valid;
  logic                  in_ready;
  dwc_pkg::wide_beat_t   out_beat;
  logic                  out_valid;
  logic                  out_ready;

  // Stimulus and expected beats from the stim file
  dwc_pkg::narrow_beat_t beat_q[$];
  int                    gap_q[$];
  dwc_pkg::wide_beat_t   exp_q[$];
  logic [63:0]           ready_pat;
  int                    n_seen;
  int                    ready_cyc;
  bit                    stim_loaded;
  // Back-pressure tracking for the stability check
  bit                    was_held;
  dwc_pkg::wide_beat_t   held_beat;

  tb_dwc_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dwc_upsize_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input logic [159:0] actual, input logic [159:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s: got %h, expected %h",
               $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // Lines are N (narrow beat), E (expected wide beat) or R (ready pattern)
  task automatic load_stim();
    int                          fd;
    int                          gap;
    int                          first;
    int                          lane;
    int                          last;
    string                       line;
    logic [`DWC_NARROW_W-1:0]    ndata;
    logic [`DWC_NARROW_STRB_W-1:0] nstrb;
    logic [`DWC_WIDE_W-1:0]      wdata;
    logic [`DWC_WIDE_STRB_W-1:0] wstrb;
    dwc_pkg::narrow_beat_t       nb;
    dwc_pkg::wide_beat_t         wb;
    fd = $fopen("verif/dwc_upsize_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stim file verif/dwc_upsize_stim.txt");
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if (line[0] == "N" &&
          $sscanf(line, "N %d %d %d %d %h %h", gap, first, lane, last, nstrb, ndata) == 6) begin
        nb.data       = ndata;
        nb.strb       = nstrb;
        nb.first      = first[0];
        nb.start_lane = lane[`DWC_LANE_IDX_W-1:0];
        nb.last       = last[0];
        beat_q.push_back(nb);
        gap_q.push_back(gap);
      end else if (line[0] == "E" && $sscanf(line, "E %d %h %h", last, wstrb, wdata) == 3) begin
        wb.word.flat = wdata;
        wb.strb      = wstrb;
        wb.last      = last[0];
        exp_q.push_back(wb);
      end else if (line[0] != "R" || $sscanf(line, "R %h", ready_pat) != 1) begin
        $display("Stim file line could not be parsed: %s", line);
        stop_with_failure();
      end
    end
    $fclose(fd);
  endtask

  // Drive one narrow beat after a random idle gap and hold it until taken
  task automatic send_beat(input dwc_pkg::narrow_beat_t beat, input int max_gap);
    int gap;
    gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
    in_valid = 1'b0;
    repeat (gap) @(negedge clk);
    in_beat  = beat;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    @(negedge clk);
  endtask

  initial begin
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    ready_pat = '1;
    n_seen    = 0;
    ready_cyc = 0;
    was_held  = 1'b0;
    void'($urandom(32'h603b));
    load_stim();
    stim_loaded = 1'b1;
    wait (rst_n);
    @(posedge clk);
    // Idle state right after reset
    check_value(out_valid, 1'b0, "out_valid after reset");
    check_value(in_ready, 1'b1, "in_ready after reset");
    check_value(u_dut.slot_strb, '0, "slot strobes after reset");
    @(negedge clk);
    foreach (beat_q[i]) begin
      send_beat(beat_q[i], gap_q[i]);
    end
    in_valid = 1'b0;
    wait (exp_q.size() == 0);
    // A few spare cycles to catch an extra wide beat
    repeat (4) @(posedge clk);
    // Nothing may be left pending in the output register or the slots
    if (!out_valid && u_dut.slot_strb == '0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("A wide beat or slot contents were left over after the last expected beat");
      stop_with_failure();
    end
  end

  // Sink ready follows the pattern, one bit per cycle, LSB first and cyclic
  initial begin
    wait (rst_n);
    @(posedge clk);
    forever begin
      @(negedge clk);
      out_ready = ready_pat[ready_cyc % 64];
      ready_cyc++;
    end
  end

  // Scoreboard and back-pressure checks, sampled at the transfer edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (was_held) begin
        check_value(out_valid, 1'b1, "out_valid dropped under back-pressure");
        check_value(out_beat, held_beat, "wide beat changed under back-pressure");
      end
      if (out_valid && !out_ready) begin
        check_value(in_ready, 1'b0, "in_ready under back-pressure");
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("A wide beat arrived when no more were expected");
          stop_with_failure();
        end else begin
          check_value(out_beat, exp_q.pop_front(), $sformatf("wide beat %0d", n_seen));
          n_seen++;
        end
      end
      was_held  = out_valid && !out_ready;
      held_beat = out_beat;
    end
  end

  // Budget of 20 cycles per narrow beat plus 100
  initial begin
    wait (stim_loaded);
    repeat (20 * beat_q.size() + 100) @(posedge clk);
    $display("The run timed out before all wide beats arrived");
    stop_with_failure();
  end

endmodule
